//--- run_sim.sh
#!/bin/sh
# Builds the memory controller testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_mem_top -o sim_mem_top
out=$(./obj_dir/sim_mem_top)
echo "$out"
echo "$out" | grep -qxF '** PASS **'

//--- sim.f
+incdir+test
verilog/mem_pkg.sv
verilog/bus_write_timing.sv
verilog/byte_ram.sv
verilog/palette_mem.sv
verilog/io_regs.sv
verilog/sound_fifo.sv
verilog/mem_top.sv
test/tb_mem_top.sv

//--- test/mem_model.svh
/*
 * Reference model for the memory controller testbench.
 * Keeps the expected contents of work RAM, both palette halves, the I/O
 * words and the sound FIFO, and computes expected words from the little
 * endian lane rules. Included inside the testbench module.
 */

`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

logic [31:0] work_model    [WORK_WORDS];
logic [31:0] pal_bg_model  [PAL_HALF_WORDS];
logic [31:0] pal_obj_model [PAL_HALF_WORDS];
logic [31:0] io_model      [IO_WORDS];
logic [31:0] fifo_model    [$];

// I/O words come out of reset as zero, the FIFO empty
function automatic void reset_model();
    for (int w = 0; w < IO_WORDS; w++) begin
        io_model[w] = '0;
    end
    fifo_model.delete();
endfunction

// Lanes touched by one write, counted in bytes from the aligned start
function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] lane);
    int         bytes;
    int         first;
    logic [3:0] mask;
    mask = 4'b0000;
    if (size <= SIZE_WORD) begin
        bytes = 1 << size;
        first = lane - (lane % bytes);
        for (int i = 0; i < bytes; i++) begin
            mask[first + i] = 1'b1;
        end
    end
    return mask;
endfunction

function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0] mask);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
            result[i*8 +: 8] = new_word[i*8 +: 8];
        end
    end
    return result;
endfunction

function automatic void io_store_model(input int idx, input logic [1:0] size,
                                       input logic [1:0] lane, input logic [31:0] data);
    logic [3:0] mask;
    mask = lane_mask(size, lane);
    if (idx == IO_FIFO_A_IDX) begin
        // Lane 0 pushes the whole word, a full FIFO drops it
        if (mask[0] && fifo_model.size() < FIFO_DEPTH) begin
            fifo_model.push_back(data);
        end
    end else if (idx == IO_IE_IF_IDX) begin
        io_model[idx] = merge_lanes(io_model[idx], data, mask & 4'b0011);
    end else begin
        io_model[idx] = merge_lanes(io_model[idx], data, mask);
    end
endfunction

// Acknowledge bits from a write to the high half of IE/IF
function automatic logic [15:0] ack_expected(input int idx, input logic [1:0] size,
                                             input logic [1:0] lane, input logic [31:0] data);
    logic [3:0]  mask;
    logic [15:0] acks;
    mask = lane_mask(size, lane);
    acks = '0;
    if (idx == IO_IE_IF_IDX) begin
        if (mask[2]) begin
            acks[7:0] = data[23:16];
        end
        if (mask[3]) begin
            acks[15:8] = data[31:24];
        end
    end
    return acks;
endfunction

function automatic logic [31:0] io_expected(input int idx, input logic [15:0] keys,
                                            input logic [15:0] flags);
    logic [31:0] word;
    word = io_model[idx];
    if (idx == IO_KEYINPUT_IDX) begin
        word[15:0] = keys;
    end else if (idx == IO_IE_IF_IDX) begin
        word[31:16] = flags;
    end else if (idx == IO_FIFO_A_IDX) begin
        word = fifo_model[0];
    end
    return word;
endfunction

`endif

//--- test/tb_mem_top.sv
/*
 * Testbench for the bus side of the memory controller.
 * Drives the CPU/DMA bus, the palette graphics ports, the I/O inputs and
 * the FIFO controls of mem_top, and checks each response against the
 * reference model. Prints one line per test, then the closing counts.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_top
    import mem_pkg::*;
();

    // About 1600 cycles of tests, limit at well over three times that
    localparam int MAX_CYCLES  = 6000;
    localparam int WORK_SLOTS  = 16;
    localparam int WORK_OPS    = 200;
    localparam int PAL_TESTED  = 32;

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] bus_addr;
    logic [1:0]  bus_size;
    logic        bus_write;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        bus_pause;
    logic [6:0]  pal_bg_gfx_addr;
    logic [6:0]  pal_obj_gfx_addr;
    logic [31:0] pal_bg_gfx_data;
    logic [31:0] pal_obj_gfx_data;
    logic [15:0] buttons;
    logic [15:0] reg_if;
    logic [15:0] reg_ie;
    logic [15:0] int_acks;
    logic        fifo_re;
    logic        fifo_clr;
    logic [31:0] fifo_val;
    logic [3:0]  fifo_size;

    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          errors_at_start = 0;
    string       check_name_q [$];
    logic [31:0] check_got_q [$];
    logic [31:0] check_exp_q [$];

    `include "mem_model.svh"

    mem_top dut0 (
        .clock            (clock),
        .reset            (reset),
        .bus_addr         (bus_addr),
        .bus_size         (bus_size),
        .bus_write        (bus_write),
        .bus_wdata        (bus_wdata),
        .bus_rdata        (bus_rdata),
        .bus_pause        (bus_pause),
        .pal_bg_gfx_addr  (pal_bg_gfx_addr),
        .pal_obj_gfx_addr (pal_obj_gfx_addr),
        .pal_bg_gfx_data  (pal_bg_gfx_data),
        .pal_obj_gfx_data (pal_obj_gfx_data),
        .buttons          (buttons),
        .reg_if           (reg_if),
        .reg_ie           (reg_ie),
        .int_acks         (int_acks),
        .fifo_re          (fifo_re),
        .fifo_clr         (fifo_clr),
        .fifo_val         (fifo_val),
        .fifo_size        (fifo_size)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // Samples are queued at falling edges and compared at the next rising edge
    always @(posedge clock) begin : compare
        string       name;
        logic [31:0] got;
        logic [31:0] exp;
        while (check_name_q.size() > 0) begin
            name = check_name_q.pop_front();
            got  = check_got_q.pop_front();
            exp  = check_exp_q.pop_front();
            check_count++;
            assert (got === exp)
            else begin
                $display("ERR %s: got %h, expected %h", name, got, exp);
                error_count++;
            end
        end
    end

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_name_q.push_back(name);
        check_got_q.push_back(got);
        check_exp_q.push_back(exp);
    endtask

    function automatic logic [31:0] work_address(input logic [10:0] idx,
                                                 input logic [10:0] mirror,
                                                 input logic [1:0] lane);
        return {REGION_WORK, mirror, idx, lane};
    endfunction

    function automatic logic [31:0] pal_address(input logic [9:0] offset);
        return {REGION_PALETTE, 14'd0, offset};
    endfunction

    function automatic logic [31:0] io_address(input int idx, input logic [1:0] lane);
        return {REGION_IO, 14'd0, idx[7:0], lane};
    endfunction

    // Read request, data valid in the following cycle
    task automatic bus_load(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clock);
        bus_addr  <= addr;
        bus_size  <= SIZE_WORD;
        bus_write <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        data = bus_rdata;
    endtask

    // Write request, data goes out in the pause cycle
    task automatic bus_store(input logic [31:0] addr, input logic [1:0] size,
                             input logic [31:0] data);
        @(posedge clock);
        bus_addr  <= addr;
        bus_size  <= size;
        bus_write <= 1'b1;
        @(posedge clock);
        bus_wdata <= data;
        @(negedge clock);
        expect_value("bus_pause", {31'd0, bus_pause}, 32'd1);
        @(posedge clock);
        bus_write <= 1'b0;
        @(negedge clock);
        expect_value("bus_pause", {31'd0, bus_pause}, 32'd0);
    endtask

    task automatic io_write(input int idx, input logic [1:0] size, input logic [1:0] lane,
                            input logic [31:0] data);
        bus_store(io_address(idx, lane), size, data);
        io_store_model(idx, size, lane, data);
    endtask

    task automatic io_check(input int idx);
        logic [31:0] got;
        bus_load(io_address(idx, 2'd0), got);
        expect_value("bus_rdata", got, io_expected(idx, buttons, reg_if));
    endtask

    task automatic finish_test(input string name);
        int errors;
        @(posedge clock);
        #1;
        errors = error_count - errors_at_start;
        errors_at_start = error_count;
        test_count++;
        if (errors == 0) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d mismatches", test_count, name, errors);
        end
    endtask

    task automatic reset_state();
        logic [31:0] got;
        @(negedge clock);
        expect_value("bus_pause", {31'd0, bus_pause}, 32'd0);
        expect_value("int_acks", {16'd0, int_acks}, 32'd0);
        expect_value("fifo_size", {28'd0, fifo_size}, 32'd0);
        bus_load(32'h0000_0010, got);
        expect_value("bus_rdata", got, 32'd0);
        bus_load(32'h0600_0004, got);
        expect_value("bus_rdata", got, 32'd0);
    endtask

    task automatic work_ram_lanes();
        logic [10:0] slot [WORK_SLOTS];
        logic [10:0] idx;
        logic [1:0]  size;
        logic [1:0]  lane;
        logic [31:0] data;
        logic [31:0] got;
        // Full words first, so later lane merges start from known data
        for (int i = 0; i < WORK_SLOTS; i++) begin
            slot[i] = 11'($urandom_range(WORK_WORDS - 1, 0));
            data = $urandom();
            bus_store(work_address(slot[i], 11'($urandom()), 2'd0), SIZE_WORD, data);
            work_model[slot[i]] = data;
        end
        for (int n = 0; n < WORK_OPS; n++) begin
            idx  = slot[$urandom_range(WORK_SLOTS - 1, 0)];
            size = 2'($urandom_range(2, 0));
            lane = 2'($urandom());
            if (size == SIZE_HALF) begin
                lane[0] = 1'b0;
            end else if (size == SIZE_WORD) begin
                lane = 2'd0;
            end
            data = $urandom();
            bus_store(work_address(idx, 11'($urandom()), lane), size, data);
            work_model[idx] = merge_lanes(work_model[idx], data, lane_mask(size, lane));
            // Read back through another mirror
            bus_load(work_address(idx, 11'($urandom()), 2'd0), got);
            expect_value("bus_rdata", got, work_model[idx]);
        end
    endtask

    task automatic check_palette(input logic [6:0] idx);
        logic [31:0] got;
        @(posedge clock);
        bus_addr         <= pal_address({1'b0, idx, 2'b00});
        bus_size         <= SIZE_WORD;
        bus_write        <= 1'b0;
        pal_bg_gfx_addr  <= idx;
        pal_obj_gfx_addr <= idx;
        @(posedge clock);
        @(negedge clock);
        expect_value("bus_rdata", bus_rdata, pal_bg_model[idx]);
        expect_value("pal_bg_gfx_data", pal_bg_gfx_data, pal_bg_model[idx]);
        expect_value("pal_obj_gfx_data", pal_obj_gfx_data, pal_obj_model[idx]);
        bus_load(pal_address(PAL_OBJ_OFFSET + {1'b0, idx, 2'b00}), got);
        expect_value("bus_rdata", got, pal_obj_model[idx]);
    endtask

    task automatic palette_split();
        logic [6:0]  idx [PAL_TESTED];
        logic [31:0] data;
        for (int i = 0; i < PAL_TESTED; i++) begin
            idx[i] = 7'($urandom());
            data = $urandom();
            bus_store(pal_address({1'b0, idx[i], 2'b00}), SIZE_WORD, data);
            pal_bg_model[idx[i]] = data;
            data = $urandom();
            bus_store(pal_address(PAL_OBJ_OFFSET + {1'b0, idx[i], 2'b00}), SIZE_WORD, data);
            pal_obj_model[idx[i]] = data;
        end
        for (int i = 0; i < PAL_TESTED; i++) begin
            check_palette(idx[i]);
        end
    endtask

    task automatic io_registers();
        logic [31:0] data;
        logic [15:0] acks;
        // Two ordinary words, built up from lane writes
        io_write(2, SIZE_WORD, 2'd0, $urandom());
        io_write(2, SIZE_BYTE, 2'd1, $urandom());
        io_write(2, SIZE_HALF, 2'd2, $urandom());
        io_check(2);
        io_write(124, SIZE_BYTE, 2'd3, $urandom());
        io_check(124);
        @(posedge clock);
        buttons <= 16'($urandom());
        reg_if  <= 16'($urandom());
        io_write(IO_KEYINPUT_IDX, SIZE_WORD, 2'd0, $urandom());
        io_check(IO_KEYINPUT_IDX);
        io_write(IO_IE_IF_IDX, SIZE_HALF, 2'd0, $urandom());
        expect_value("reg_ie", {16'd0, reg_ie}, {16'd0, io_model[IO_IE_IF_IDX][15:0]});
        expect_value("int_acks", {16'd0, int_acks}, 32'd0);
        io_check(IO_IE_IF_IDX);
        // Acknowledge lasts exactly one cycle
        data = $urandom();
        acks = ack_expected(IO_IE_IF_IDX, SIZE_HALF, 2'd2, data);
        io_write(IO_IE_IF_IDX, SIZE_HALF, 2'd2, data);
        expect_value("int_acks", {16'd0, int_acks}, {16'd0, acks});
        @(negedge clock);
        expect_value("int_acks", {16'd0, int_acks}, 32'd0);
        expect_value("reg_ie", {16'd0, reg_ie}, {16'd0, io_model[IO_IE_IF_IDX][15:0]});
    endtask

    task automatic pop_fifo();
        if (fifo_model.size() > 0) begin
            expect_value("fifo_val", fifo_val, fifo_model[0]);
        end
        @(posedge clock);
        fifo_re <= 1'b1;
        @(posedge clock);
        fifo_re <= 1'b0;
        if (fifo_model.size() > 0) begin
            void'(fifo_model.pop_front());
        end
        @(negedge clock);
        expect_value("fifo_size", {28'd0, fifo_size}, 32'(fifo_model.size()));
    endtask

    task automatic fifo_fill_and_drain();
        for (int k = 0; k < 10; k++) begin
            io_write(IO_FIFO_A_IDX, SIZE_WORD, 2'd0, $urandom());
            expect_value("fifo_size", {28'd0, fifo_size}, 32'(fifo_model.size()));
        end
        expect_value("fifo_val", fifo_val, fifo_model[0]);
        io_check(IO_FIFO_A_IDX);
        for (int k = 0; k < 5; k++) begin
            pop_fifo();
        end
        @(posedge clock);
        fifo_clr <= 1'b1;
        @(posedge clock);
        fifo_clr <= 1'b0;
        fifo_model.delete();
        @(negedge clock);
        expect_value("fifo_size", {28'd0, fifo_size}, 32'd0);
        // Pop on an empty FIFO does nothing
        pop_fifo();
    endtask

    initial begin
        void'($urandom(32'h2abf));
        reset            <= 1'b1;
        bus_addr         <= '0;
        bus_size         <= SIZE_WORD;
        bus_write        <= 1'b0;
        bus_wdata        <= '0;
        pal_bg_gfx_addr  <= '0;
        pal_obj_gfx_addr <= '0;
        buttons          <= 16'h03ff;
        reg_if           <= '0;
        fifo_re          <= 1'b0;
        fifo_clr         <= 1'b0;
        reset_model();
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        reset_state();
        finish_test("reset state");
        work_ram_lanes();
        finish_test("work RAM lanes");
        palette_split();
        finish_test("palette split");
        io_registers();
        finish_test("I/O registers");
        fifo_fill_and_drain();
        finish_test("sound FIFO");

        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_mem_top

`default_nettype wire

//--- verilog/bus_write_timing.sv
/*
 * Request latch and write pause for the CPU/DMA bus.
 * Every request is registered for one cycle. An accepted write raises
 * bus_pause for the next cycle, in which the master drives its data and
 * the byte-lane enables are decoded from the latched size and lane.
 */

`timescale 1ns/1ps
`default_nettype none

module bus_write_timing
    import mem_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [31:0]          bus_addr,
    input  logic [1:0]           bus_size,
    input  logic                 bus_write,
    output logic                 bus_pause,
    output bus_addr_t            lat_addr,
    output logic                 lat_write,
    output bus_addr_t            mem_addr,
    output logic [LANES-1:0]     byte_we
);

    logic [1:0] lat_size;
    logic       write_taken;

    // A held write during pause is not taken a second time
    assign write_taken = bus_write & ~bus_pause;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lat_addr  <= '0;
            lat_size  <= SIZE_BYTE;
            lat_write <= 1'b0;
            bus_pause <= 1'b0;
        end else begin
            lat_addr  <= bus_addr;
            lat_size  <= bus_size;
            lat_write <= write_taken;
            bus_pause <= write_taken;
        end
    end

    // Memories see the held address while the write data is on the bus
    assign mem_addr = lat_write ? lat_addr : bus_addr;

    // Little endian lane enables
    always_comb begin
        byte_we = '0;
        if (lat_write) begin
            case (lat_size)
                SIZE_BYTE: byte_we[lat_addr.as_word.lane] = 1'b1;
                SIZE_HALF: byte_we = lat_addr.as_word.lane[1] ? 4'b1100 : 4'b0011;
                SIZE_WORD: byte_we = '1;
                default:   byte_we = '0;
            endcase
        end
    end

endmodule : bus_write_timing

`default_nettype wire

//--- verilog/byte_ram.sv
/*
 * Dual port word RAM with byte enables.
 * Port a is the bus side and writes any set of lanes at the edge.
 * Port b is read only. Both ports return data one cycle after the
 * address. DEPTH sets the number of words.
 */

`timescale 1ns/1ps
`default_nettype none

module byte_ram
    import mem_pkg::*;
#(
    parameter int DEPTH = 128
) (
    input  logic                     clock,
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  logic [LANES-1:0]         a_we,
    input  logic [WORD_W-1:0]        a_wdata,
    output logic [WORD_W-1:0]        a_rdata,
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    output logic [WORD_W-1:0]        b_rdata
);

    logic [WORD_W-1:0] mem [DEPTH];

    // Bus port, old data is returned on a write cycle
    always_ff @(posedge clock) begin
        for (int i = 0; i < LANES; i++) begin
            if (a_we[i]) begin
                mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
            end
        end
        a_rdata <= mem[a_addr];
    end

    // Read only port
    always_ff @(posedge clock) begin
        b_rdata <= mem[b_addr];
    end

endmodule : byte_ram

`default_nettype wire

//--- verilog/io_regs.sv
/*
 * I/O register block for region 0x04.
 * Ordinary words are byte writable storage. KEYINPUT reads the buttons
 * in its low half, the IE/IF word reads the interrupt flags in its high
 * half and turns writes there into one-cycle acknowledges, and the sound
 * FIFO A word pushes into the FIFO. Reads decode the latched address.
 */

`timescale 1ns/1ps
`default_nettype none

module io_regs
    import mem_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                sel,
    input  bus_addr_t           lat_addr,
    input  logic [LANES-1:0]    byte_we,
    input  logic [WORD_W-1:0]   bus_wdata,
    output logic [WORD_W-1:0]   rdata,
    input  logic [15:0]         buttons,
    input  logic [15:0]         reg_if,
    output logic [15:0]         reg_ie,
    output logic [15:0]         int_acks,
    output logic                fifo_push,
    output logic [WORD_W-1:0]   fifo_wdata,
    input  logic [WORD_W-1:0]   fifo_head
);

    logic [WORD_W-1:0]           regs [IO_WORDS];
    logic [21:0]                 io_word;
    logic [$clog2(IO_WORDS)-1:0] io_idx;
    logic                        in_range;
    logic [LANES-1:0]            io_we;
    logic [LANES-1:0]            store_we;
    logic [1:0]                  ack_we;

    assign io_word  = lat_addr.as_region.offset[23:2];
    assign io_idx   = io_word[$clog2(IO_WORDS)-1:0];
    assign in_range = io_word < IO_WORDS;
    assign io_we    = (sel && in_range) ? byte_we : '0;

    // Lanes that land in plain storage
    always_comb begin
        store_we = io_we;
        if (io_idx == IO_FIFO_A_IDX) begin
            store_we = '0;
        end else if (io_idx == IO_IE_IF_IDX) begin
            store_we[3:2] = 2'b00;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int w = 0; w < IO_WORDS; w++) begin
                regs[w] <= '0;
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (store_we[i]) begin
                    regs[io_idx][i*8 +: 8] <= bus_wdata[i*8 +: 8];
                end
            end
        end
    end

    assign reg_ie = regs[IO_IE_IF_IDX][15:0];

    // Acknowledge bits last one cycle; a new write beats the clear
    assign ack_we = (io_idx == IO_IE_IF_IDX) ? io_we[3:2] : 2'b00;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            int_acks <= '0;
        end else begin
            int_acks[7:0]  <= ack_we[0] ? bus_wdata[23:16] : 8'h00;
            int_acks[15:8] <= ack_we[1] ? bus_wdata[31:24] : 8'h00;
        end
    end

    // Sound FIFO A takes a word on a lane 0 write
    assign fifo_push  = (io_idx == IO_FIFO_A_IDX) && io_we[0];
    assign fifo_wdata = bus_wdata;

    always_comb begin
        rdata = '0;
        if (in_range) begin
            rdata = regs[io_idx];
            if (io_idx == IO_KEYINPUT_IDX) begin
                rdata[15:0] = buttons;
            end else if (io_idx == IO_IE_IF_IDX) begin
                rdata[31:16] = reg_if;
            end else if (io_idx == IO_FIFO_A_IDX) begin
                rdata = fifo_head;
            end
        end
    end

endmodule : io_regs

`default_nettype wire

//--- verilog/mem_pkg.sv
/*
 * Shared definitions for the console memory controller.
 * Holds the bus address map, the transfer size codes, word and lane
 * widths, the depths of each memory, and the bus address type.
 * Modules pull these in with a wildcard import in their header.
 */

`default_nettype none

package mem_pkg;

    // Data path
    localparam int WORD_W = 32;
    localparam int LANES  = 4;

    // Transfer size codes on bus_size
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // Regions, taken from the top address byte
    localparam logic [7:0] REGION_WORK    = 8'h03;
    localparam logic [7:0] REGION_IO      = 8'h04;
    localparam logic [7:0] REGION_PALETTE = 8'h05;

    // Work RAM is reduced and aliases above its size
    localparam int WORK_WORDS = 2048;

    // Palette RAM, background half first, then the object half
    localparam int          PAL_HALF_WORDS = 128;
    localparam logic [9:0]  PAL_OBJ_OFFSET = 10'h200;

    // I/O block covers offsets 0x000 to 0x20F
    localparam int IO_WORDS        = 132;
    localparam int IO_KEYINPUT_IDX = 76;
    localparam int IO_IE_IF_IDX    = 128;
    localparam int IO_FIFO_A_IDX   = 40;

    // DMA sound FIFO
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_COUNT_W = 4;

    /*
     * Bus address, seen either as region plus byte offset, or as
     * word index plus byte lane
     */
    typedef union packed {
        struct packed {
            logic [7:0]  region;
            logic [23:0] offset;
        } as_region;
        struct packed {
            logic [29:0] word;
            logic [1:0]  lane;
        } as_word;
    } bus_addr_t;

endpackage : mem_pkg

`default_nettype wire

//--- verilog/mem_top.sv
/*
 * Bus side of the console memory controller.
 * Reads return on the cycle after the address. A write pauses the bus
 * for one cycle while the master drives its data. Work RAM, palette RAM
 * and the I/O block are mapped; other regions read as zero. The palette
 * also feeds the graphics pipeline, and the I/O block feeds one sound FIFO.
 */

`timescale 1ns/1ps
`default_nettype none

module mem_top
    import mem_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic [31:0]                       bus_addr,
    input  logic [1:0]                        bus_size,
    input  logic                              bus_write,
    input  logic [WORD_W-1:0]                 bus_wdata,
    output logic [WORD_W-1:0]                 bus_rdata,
    output logic                              bus_pause,
    input  logic [$clog2(PAL_HALF_WORDS)-1:0] pal_bg_gfx_addr,
    input  logic [$clog2(PAL_HALF_WORDS)-1:0] pal_obj_gfx_addr,
    output logic [WORD_W-1:0]                 pal_bg_gfx_data,
    output logic [WORD_W-1:0]                 pal_obj_gfx_data,
    input  logic [15:0]                       buttons,
    input  logic [15:0]                       reg_if,
    output logic [15:0]                       reg_ie,
    output logic [15:0]                       int_acks,
    input  logic                              fifo_re,
    input  logic                              fifo_clr,
    output logic [WORD_W-1:0]                 fifo_val,
    output logic [FIFO_COUNT_W-1:0]           fifo_size
);

    bus_addr_t          lat_addr;
    bus_addr_t          mem_addr;
    logic               lat_write;
    logic [LANES-1:0]   byte_we;
    logic               sel_work;
    logic               sel_pal;
    logic               sel_io;
    logic [LANES-1:0]   work_we;
    logic [WORD_W-1:0]  work_rdata;
    logic [WORD_W-1:0]  pal_rdata;
    logic [WORD_W-1:0]  io_rdata;
    logic               fifo_push;
    logic [WORD_W-1:0]  fifo_wdata;

    bus_write_timing timing (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .bus_pause (bus_pause),
        .lat_addr  (lat_addr),
        .lat_write (lat_write),
        .mem_addr  (mem_addr),
        .byte_we   (byte_we)
    );

    // Region of the request now being completed
    assign sel_work = lat_addr.as_region.region == REGION_WORK;
    assign sel_pal  = lat_addr.as_region.region == REGION_PALETTE;
    assign sel_io   = lat_addr.as_region.region == REGION_IO;

    assign work_we = (sel_work && lat_write) ? byte_we : '0;

    // Upper word bits are dropped, so work RAM aliases
    byte_ram #(.DEPTH(WORK_WORDS)) work_ram (
        .clock   (clock),
        .a_addr  (mem_addr.as_word.word[$clog2(WORK_WORDS)-1:0]),
        .a_we    (work_we),
        .a_wdata (bus_wdata),
        .a_rdata (work_rdata),
        .b_addr  ('0),
        .b_rdata ()
    );

    palette_mem palette (
        .clock        (clock),
        .sel          (sel_pal),
        .mem_addr     (mem_addr),
        .lat_addr     (lat_addr),
        .byte_we      (byte_we),
        .bus_wdata    (bus_wdata),
        .bus_rdata    (pal_rdata),
        .bg_gfx_addr  (pal_bg_gfx_addr),
        .obj_gfx_addr (pal_obj_gfx_addr),
        .bg_gfx_data  (pal_bg_gfx_data),
        .obj_gfx_data (pal_obj_gfx_data)
    );

    io_regs io (
        .clock      (clock),
        .reset      (reset),
        .sel        (sel_io),
        .lat_addr   (lat_addr),
        .byte_we    (byte_we),
        .bus_wdata  (bus_wdata),
        .rdata      (io_rdata),
        .buttons    (buttons),
        .reg_if     (reg_if),
        .reg_ie     (reg_ie),
        .int_acks   (int_acks),
        .fifo_push  (fifo_push),
        .fifo_wdata (fifo_wdata),
        .fifo_head  (fifo_val)
    );

    sound_fifo fifo_a (
        .clock (clock),
        .reset (reset),
        .push  (fifo_push),
        .wdata (fifo_wdata),
        .pop   (fifo_re),
        .clr   (fifo_clr),
        .head  (fifo_val),
        .count (fifo_size)
    );

    // Unmapped regions read as zero
    always_comb begin
        if (sel_work) begin
            bus_rdata = work_rdata;
        end else if (sel_pal) begin
            bus_rdata = pal_rdata;
        end else if (sel_io) begin
            bus_rdata = io_rdata;
        end else begin
            bus_rdata = '0;
        end
    end

endmodule : mem_top

`default_nettype wire

//--- verilog/palette_mem.sv
/*
 * Palette RAM, split into a background half and an object half.
 * The bus reaches both halves through the palette region; the graphics
 * pipeline reads each half through its own port by word index.
 * The region mirrors every 1 KB.
 */

`timescale 1ns/1ps
`default_nettype none

module palette_mem
    import mem_pkg::*;
(
    input  logic                              clock,
    input  logic                              sel,
    input  bus_addr_t                         mem_addr,
    input  bus_addr_t                         lat_addr,
    input  logic [LANES-1:0]                  byte_we,
    input  logic [WORD_W-1:0]                 bus_wdata,
    output logic [WORD_W-1:0]                 bus_rdata,
    input  logic [$clog2(PAL_HALF_WORDS)-1:0] bg_gfx_addr,
    input  logic [$clog2(PAL_HALF_WORDS)-1:0] obj_gfx_addr,
    output logic [WORD_W-1:0]                 bg_gfx_data,
    output logic [WORD_W-1:0]                 obj_gfx_data
);

    logic [9:0]         bg_off;
    logic [9:0]         obj_off;
    logic               lat_in_bg;
    logic [LANES-1:0]   bg_we;
    logic [LANES-1:0]   obj_we;
    logic [WORD_W-1:0]  bg_rdata;
    logic [WORD_W-1:0]  obj_rdata;

    assign bg_off  = mem_addr.as_region.offset[9:0];
    assign obj_off = mem_addr.as_region.offset[9:0] - PAL_OBJ_OFFSET;

    // Half selection always uses the latched offset
    assign lat_in_bg = lat_addr.as_region.offset[9:0] < PAL_OBJ_OFFSET;

    assign bg_we  = (sel && lat_in_bg)  ? byte_we : '0;
    assign obj_we = (sel && !lat_in_bg) ? byte_we : '0;

    byte_ram #(.DEPTH(PAL_HALF_WORDS)) bg_ram (
        .clock   (clock),
        .a_addr  (bg_off[8:2]),
        .a_we    (bg_we),
        .a_wdata (bus_wdata),
        .a_rdata (bg_rdata),
        .b_addr  (bg_gfx_addr),
        .b_rdata (bg_gfx_data)
    );

    byte_ram #(.DEPTH(PAL_HALF_WORDS)) obj_ram (
        .clock   (clock),
        .a_addr  (obj_off[8:2]),
        .a_we    (obj_we),
        .a_wdata (bus_wdata),
        .a_rdata (obj_rdata),
        .b_addr  (obj_gfx_addr),
        .b_rdata (obj_gfx_data)
    );

    assign bus_rdata = lat_in_bg ? bg_rdata : obj_rdata;

endmodule : palette_mem

`default_nettype wire

//--- verilog/sound_fifo.sv
/*
 * Eight entry DMA sound FIFO.
 * Words are pushed from the I/O block and popped by the sound mixer.
 * The head word is always visible on head, count gives the fill level.
 * Push when full and pop when empty are ignored; clr empties it at the
 * next edge.
 */

`timescale 1ns/1ps
`default_nettype none

module sound_fifo
    import mem_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    push,
    input  logic [WORD_W-1:0]       wdata,
    input  logic                    pop,
    input  logic                    clr,
    output logic [WORD_W-1:0]       head,
    output logic [FIFO_COUNT_W-1:0] count
);

    logic [WORD_W-1:0]             buffer [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] get_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] put_ptr;
    logic                          full;
    logic                          empty;
    logic                          do_push;
    logic                          do_pop;

    assign full    = count == FIFO_COUNT_W'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            get_ptr <= '0;
            put_ptr <= '0;
            count   <= '0;
        end else if (clr) begin
            get_ptr <= '0;
            put_ptr <= '0;
            count   <= '0;
        end else begin
            if (do_push) begin
                put_ptr <= put_ptr + 1'b1;
            end
            if (do_pop) begin
                get_ptr <= get_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_push && !clr) begin
            buffer[put_ptr] <= wdata;
        end
    end

    assign head = buffer[get_ptr];

endmodule : sound_fifo

`default_nettype wire
